//--- Makefile
# Verilator build and run of the MII transmit testbench.
SIM = obj_dir/mii_tx_sim

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module mii_tx_tb -f all.f -o mii_tx_sim
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: help test clean

//--- all.f
hdl/mac_byte_pkg.sv
hdl/mii_line_pkg.sv
hdl/tx_byte_fifo.sv
hdl/ifg_timer.sv
hdl/tx_nibble_fsm.sv
hdl/nibble_serializer.sv
hdl/mii_tx_top.sv
tb/mii_tx_checker.sv
tb/mii_tx_tb.sv

//--- hdl/ifg_timer.sv
// interframe gap down-counter. IFG_CYCLES must be at least 1, a new load restarts a running gap.
`timescale 1ns/1ps

module ifg_timer #(
	parameter int IFG_CYCLES = 24               // gap length in clock cycles.
) (
	input  logic phy_tx_clk,
	input  logic tx_rst2,
	input  logic gap_start,                     // one cycle load pulse.
	output logic gap_busy                       // high while the count is nonzero.
);

	// ************************************************************
	// counter
	// ************************************************************

	localparam int CW = $clog2(IFG_CYCLES + 1);      // wide enough to hold the load value.
	localparam logic [CW-1:0] LOAD = CW'(IFG_CYCLES);

	logic [CW-1:0] count;                       // cycles left in the gap.

	always_ff @(posedge phy_tx_clk) begin
		if (tx_rst2) begin
			count <= '0;                        // no gap after reset.
		end else if (gap_start) begin
			count <= LOAD;                      // load wins over decrement.
		end else if (count != '0) begin
			count <= count - 1'b1;              // stop at zero.
		end
	end

	// busy goes low on the cycle the count reaches zero
	assign gap_busy = |count;

endmodule

//--- hdl/mac_byte_pkg.sv
// host byte types only. Carries no logic and assumes the host writes whole bytes.

package mac_byte_pkg;

	// ************************************************************
	// host side data
	// ************************************************************

	localparam int BYTE_W = 8;                  // bits per host byte.

	typedef logic [BYTE_W-1:0] byte_t;          // one byte written by the host.

	localparam int NIB_W = BYTE_W / 2;          // each byte goes out as two halves.

endpackage

//--- hdl/mii_line_pkg.sv
// MII transmit line types. Only tx_en and tx_d are modeled, no tx_er and no collision input.

package mii_line_pkg;

	// ************************************************************
	// line encoding
	// ************************************************************

	typedef logic [3:0] nibble_t;               // one MII data nibble.

	typedef struct packed {
		logic    tx_en;                         // frame valid on the wire.
		nibble_t tx_d;                          // data nibble, zero while idle.
	} mii_tx_s;                                 // 5 bits in all.

	// ************************************************************
	// transmit sequencing
	// ************************************************************

	typedef enum logic [1:0] {
		tx_idle = 2'd0,                         // waiting for data, permission and gap.
		tx_lo   = 2'd1,                         // low nibble of head on its way out.
		tx_hi   = 2'd2,                         // high nibble, head is popped here.
		tx_gap  = 2'd3                          // interframe gap running.
	} tx_state_e;

endpackage

//--- hdl/mii_tx_top.sv
// MII transmit path on one clock. The host must run on phy_tx_clk, there is no preamble, CRC or collision handling.
`timescale 1ns/1ps

module mii_tx_top
	import mac_byte_pkg::*;
	import mii_line_pkg::*;
#(
	parameter int FIFO_AW    = 6,               // FIFO depth is 2**FIFO_AW.
	parameter int IFG_CYCLES = 24               // minimum idle cycles between frames.
) (
	input  logic    phy_tx_clk,
	input  logic    tx_rst2,
	input  logic    stb,                        // host write strobe.
	input  byte_t   data,                       // host byte.
	output logic    full,                       // writes are lost while high.
	input  logic    can_tx,                     // host allows transmission.
	output logic    empty,                      // FIFO empty, one cycle late.
	output mii_tx_s mii_tx                      // to the PHY.
);

	// ************************************************************
	// internal nets
	// ************************************************************

	byte_t head;                                // FIFO head byte.
	logic  fifo_empty;
	logic  more_than_one;
	logic  pop;
	logic  gap_start;
	logic  gap_busy;
	logic  drive;
	logic  hi_sel;

	// host empty flag, registered copy of the FIFO state
	always_ff @(posedge phy_tx_clk) begin
		if (tx_rst2) begin
			empty <= 1'b1;                      // FIFO starts empty.
		end else begin
			empty <= fifo_empty;
		end
	end

	// ************************************************************
	// datapath and control
	// ************************************************************

	tx_byte_fifo #(.FIFO_AW(FIFO_AW)) u_fifo (
		.phy_tx_clk    (phy_tx_clk),
		.tx_rst2       (tx_rst2),
		.stb           (stb),
		.data          (data),
		.pop           (pop),
		.head          (head),
		.full          (full),
		.fifo_empty    (fifo_empty),
		.more_than_one (more_than_one)
	);

	ifg_timer #(.IFG_CYCLES(IFG_CYCLES)) u_ifg (
		.phy_tx_clk (phy_tx_clk),
		.tx_rst2    (tx_rst2),
		.gap_start  (gap_start),
		.gap_busy   (gap_busy)
	);

	tx_nibble_fsm u_fsm (
		.phy_tx_clk    (phy_tx_clk),
		.tx_rst2       (tx_rst2),
		.can_tx        (can_tx),
		.fifo_empty    (fifo_empty),
		.more_than_one (more_than_one),
		.gap_busy      (gap_busy),
		.pop           (pop),
		.gap_start     (gap_start),
		.drive         (drive),
		.hi_sel        (hi_sel)
	);

	nibble_serializer u_ser (
		.phy_tx_clk (phy_tx_clk),
		.tx_rst2    (tx_rst2),
		.head       (head),
		.drive      (drive),
		.hi_sel     (hi_sel),
		.mii_tx     (mii_tx)
	);

endmodule

//--- hdl/nibble_serializer.sv
// nibble output register. Output lags the sequencer by one cycle, tx_d is forced to zero when idle.
`timescale 1ns/1ps

module nibble_serializer
	import mac_byte_pkg::*;
	import mii_line_pkg::*;
(
	input  logic    phy_tx_clk,
	input  logic    tx_rst2,
	input  byte_t   head,                       // byte at the FIFO head.
	input  logic    drive,                      // a nibble is due this cycle.
	input  logic    hi_sel,                     // upper half of head.
	output mii_tx_s mii_tx                      // registered MII output.
);

	// ************************************************************
	// nibble select
	// ************************************************************

	nibble_t nib_sel;                           // half of head chosen by hi_sel.
	mii_tx_s mii_nxt;                           // value for the next edge.

	assign nib_sel = hi_sel ? head[2*NIB_W-1:NIB_W] : head[NIB_W-1:0]; // low half first.

	always_comb begin
		mii_nxt.tx_en = drive;
		mii_nxt.tx_d  = drive ? nib_sel : '0;   // quiet data lines between frames.
	end

	// ************************************************************
	// output register
	// ************************************************************

	always_ff @(posedge phy_tx_clk) begin
		if (tx_rst2) begin
			mii_tx <= '0;                       // tx_en low, tx_d zero.
		end else begin
			mii_tx <= mii_nxt;
		end
	end

endmodule

//--- hdl/tx_byte_fifo.sv
// single clock FWFT byte FIFO. Depth is 2**FIFO_AW, writes while full are dropped, pop on empty is ignored.
`timescale 1ns/1ps

module tx_byte_fifo
	import mac_byte_pkg::*;
#(
	parameter int FIFO_AW = 6                   // address width, depth is 2**FIFO_AW.
) (
	input  logic  phy_tx_clk,
	input  logic  tx_rst2,
	input  logic  stb,                          // host write strobe.
	input  byte_t data,                         // host write byte.
	input  logic  pop,                          // discard head at this edge.
	output byte_t head,                         // oldest byte, valid while not empty.
	output logic  full,
	output logic  fifo_empty,
	output logic  more_than_one                 // a byte follows the head.
);

	// ************************************************************
	// storage and pointers
	// ************************************************************

	localparam logic [FIFO_AW:0] DEPTH = {1'b1, {FIFO_AW{1'b0}}}; // occupancy when full.

	byte_t              mem [2**FIFO_AW];       // payload only, no reset.
	logic [FIFO_AW-1:0] wr_ptr;                 // next slot to write.
	logic [FIFO_AW-1:0] rd_ptr;                 // slot holding head.
	logic [FIFO_AW:0]   count;                  // bytes stored, one extra bit for full.
	logic               push;                   // accepted write.
	logic               pull;                   // accepted pop.

	assign push = stb & ~full;                  // full drops the byte.
	assign pull = pop & ~fifo_empty;            // guard against a stray pop.

	always_ff @(posedge phy_tx_clk) begin
		if (push) begin
			mem[wr_ptr] <= data;                // write lands at the edge.
		end
	end

	// ************************************************************
	// pointer and count update
	// ************************************************************

	always_ff @(posedge phy_tx_clk) begin
		if (tx_rst2) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;                       // comes out of reset empty.
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;        // wraps at the power of two.
			end
			if (pull) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pull})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;        // both or neither, level unchanged.
			endcase
		end
	end

	// ************************************************************
	// flags and head
	// ************************************************************

	assign head          = mem[rd_ptr];         // fall through, no read latency.
	assign fifo_empty    = (count == '0);
	assign full          = (count == DEPTH);
	assign more_than_one = (count > 1);         // head plus at least one more.

endmodule

//--- hdl/tx_nibble_fsm.sv
// transmit sequencer. Frames stop only on byte boundaries, and no preamble or CRC is inserted.
`timescale 1ns/1ps

module tx_nibble_fsm
	import mii_line_pkg::*;
(
	input  logic phy_tx_clk,
	input  logic tx_rst2,
	input  logic can_tx,                        // host permission level.
	input  logic fifo_empty,
	input  logic more_than_one,                 // another byte behind head.
	input  logic gap_busy,                      // timer still counting.
	output logic pop,                           // drop head at this edge.
	output logic gap_start,                     // load the gap timer.
	output logic drive,                         // put a nibble on the wire.
	output logic hi_sel                         // pick the high nibble.
);

	// ************************************************************
	// state register
	// ************************************************************

	tx_state_e state;                           // current state.
	tx_state_e state_nxt;                       // next state.
	logic      frame_more;                      // frame carries on after this byte.

	assign frame_more = can_tx & more_than_one; // checked only in tx_hi.

	always_ff @(posedge phy_tx_clk) begin
		if (tx_rst2) begin
			state <= tx_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// ************************************************************
	// transitions
	// ************************************************************

	always_comb begin
		state_nxt = state;                      // hold by default.
		case (state)
			tx_idle: begin
				if (can_tx && !fifo_empty && !gap_busy) begin
					state_nxt = tx_lo;          // start a frame.
				end
			end
			tx_lo: begin
				state_nxt = tx_hi;              // a byte is never split.
			end
			tx_hi: begin
				if (frame_more) begin
					state_nxt = tx_lo;          // next byte follows directly.
				end else begin
					state_nxt = tx_gap;         // end of frame.
				end
			end
			tx_gap: begin
				if (!gap_busy) begin
					state_nxt = tx_idle;        // gap has run out.
				end
			end
			default: begin
				state_nxt = tx_idle;
			end
		endcase
	end

	// ************************************************************
	// outputs, decoded from state
	// ************************************************************

	assign drive     = (state == tx_lo) || (state == tx_hi);
	assign hi_sel    = (state == tx_hi);
	assign pop       = (state == tx_hi);        // head is done after its high half.
	assign gap_start = (state == tx_hi) && !frame_more; // same edge as entering tx_gap.

endmodule

//--- tb/mii_tx_checker.sv
// sequencing checks for tx_nibble_fsm, bound from the testbench. All checks are off during reset.
`timescale 1ns/1ps

module mii_tx_checker
	import mii_line_pkg::*;
(
	input logic      phy_tx_clk,
	input logic      tx_rst2,
	input tx_state_e state,                     // sequencer state.
	input logic      pop,                       // FIFO head discard.
	input logic      gap_start                  // gap timer load.
);

	// ************************************************************
	// state order
	// ************************************************************

	a_lo_to_hi: assert property (@(posedge phy_tx_clk) disable iff (tx_rst2)
		(state == tx_lo) |=> (state == tx_hi))
		else $error("tx_lo was not followed by tx_hi");

	a_pop_in_hi: assert property (@(posedge phy_tx_clk) disable iff (tx_rst2)
		pop |-> (state == tx_hi))
		else $error("pop outside tx_hi");

	// ************************************************************
	// gap start only on the way out of a frame
	// ************************************************************

	a_gap_from_hi: assert property (@(posedge phy_tx_clk) disable iff (tx_rst2)
		gap_start |-> (state == tx_hi))
		else $error("gap_start outside tx_hi");

	a_gap_enters_gap: assert property (@(posedge phy_tx_clk) disable iff (tx_rst2)
		gap_start |=> (state == tx_gap))
		else $error("gap_start not followed by tx_gap");

	// every entry into tx_gap from tx_hi carried a load pulse
	a_gap_has_start: assert property (@(posedge phy_tx_clk) disable iff (tx_rst2)
		((state == tx_gap) && ($past(state) == tx_hi)) |-> $past(gap_start))
		else $error("tx_gap entered without gap_start");

endmodule

//--- tb/mii_tx_tb.sv
// testbench for mii_tx_top with a 16 byte FIFO and a 12 cycle gap. Needs timing support.
`timescale 1ns/1ps

module mii_tx_tb
	import mac_byte_pkg::*;
	import mii_line_pkg::*;
();

	localparam int FIFO_AW      = 4;
	localparam int IFG_CYCLES   = 12;
	localparam int DEPTH        = 2**FIFO_AW;                // 16 bytes.
	localparam int RANDOM_BYTES = 300;
	localparam int TOTAL_BYTES  = 19 + RANDOM_BYTES + 1 + DEPTH; // every byte the tests write.
	localparam int CYCLE_LIMIT  = 2 * TOTAL_BYTES * 2 + TOTAL_BYTES * (IFG_CYCLES + 6) + 200;
	localparam int DRAIN_LIMIT  = 200;                       // one full FIFO plus gap, with margin.

	logic    phy_tx_clk;
	logic    tx_rst2;
	logic    stb;
	byte_t   data;
	logic    full;
	logic    can_tx;
	logic    empty;
	mii_tx_s mii_tx;

	byte_t      exp_q[$];                   // accepted bytes not yet seen on the line.
	int         accepted_total = 0;
	int         frames         = 0;
	int         frame_len      = 0;         // tx_en cycles in the current frame.
	int         last_frame_len = 0;
	int         low_run        = 0;         // tx_en low cycles since the last frame.
	logic       in_frame;
	logic       have_lo;
	nibble_t    lo_nib;
	int         checks    = 0;
	int         errors    = 0;
	int         tests_run = 0;
	int         cycles    = 0;
	logic [31:0] rng;

	mii_tx_top #(.FIFO_AW(FIFO_AW), .IFG_CYCLES(IFG_CYCLES)) uut (
		.phy_tx_clk (phy_tx_clk),
		.tx_rst2    (tx_rst2),
		.stb        (stb),
		.data       (data),
		.full       (full),
		.can_tx     (can_tx),
		.empty      (empty),
		.mii_tx     (mii_tx)
	);

	bind tx_nibble_fsm mii_tx_checker u_chk (
		.phy_tx_clk (phy_tx_clk),
		.tx_rst2    (tx_rst2),
		.state      (state),
		.pop        (pop),
		.gap_start  (gap_start)
	);

	initial begin
		phy_tx_clk = 1'b0;
		forever #50 phy_tx_clk = ~phy_tx_clk;   // 100 ns period.
	end

	// ************************************************************
	// helpers
	// ************************************************************

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0d ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		$display("test %0d %s: %s", tests_run, name, (errors == err_before) ? "passed" : "FAILED");
	endtask

	// waits until every accepted byte has left and the frame has ended
	task automatic wait_drain(input string what);
		int n;
		n = 0;
		@(posedge phy_tx_clk);
		while ((exp_q.size() != 0 || in_frame) && n < DRAIN_LIMIT) begin
			@(posedge phy_tx_clk);
			n++;
		end
		if (exp_q.size() != 0 || in_frame) begin
			errors++;
			$display("%s: %0d bytes still not sent after %0d cycles", what, exp_q.size(), n);
		end
	endtask

	// ************************************************************
	// reference model, sampled on the falling edge
	// ************************************************************

	always @(negedge phy_tx_clk) begin : monitor
		byte_t got_byte;
		if (tx_rst2 !== 1'b0) begin
			in_frame  = 1'b0;                   // also covers X before the first reset edge.
			have_lo   = 1'b0;
			frame_len = 0;
			low_run   = 0;
		end else begin
			if (stb && !full) begin
				exp_q.push_back(data);          // full low at this edge means accepted.
				accepted_total++;
			end
			if (mii_tx.tx_en) begin
				if (!in_frame) begin
					if (frames > 0) begin
						check_value(32'(low_run >= IFG_CYCLES), 32'd1, "interframe gap too short");
					end
					frame_len = 0;
					have_lo   = 1'b0;           // a frame opens with a low nibble.
				end
				frame_len++;
				if (!have_lo) begin
					lo_nib  = mii_tx.tx_d;
					have_lo = 1'b1;
				end else begin
					got_byte = {mii_tx.tx_d, lo_nib};
					have_lo  = 1'b0;
					if (exp_q.size() == 0) begin
						errors++;
						$display("byte 0x%02h sent at %0d ns with nothing written", got_byte, $time);
					end else begin
						check_value(32'(got_byte), 32'(exp_q.pop_front()), "byte on MII");
					end
				end
				in_frame = 1'b1;
			end else begin
				if (in_frame) begin
					frames++;
					last_frame_len = frame_len;
					check_value(32'(frame_len[0]), 32'd0, "odd tx_en cycle count in frame");
					low_run = 0;
				end
				low_run++;
				in_frame = 1'b0;
				check_value(32'(mii_tx.tx_d), 32'd0, "tx_d not zero while idle");
			end
		end
	end

	// run limit
	always @(posedge phy_tx_clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// ************************************************************
	// test sequence
	// ************************************************************

	initial begin
		int err0;
		int start_acc;
		int start_frames;
		int first_full;
		int stop_edge;
		int n;
		tx_rst2 = 1'b1;
		stb     = 1'b0;
		data    = '0;
		can_tx  = 1'b0;
		rng     = 32'd77;                       // fixed seed.
		repeat (2) @(posedge phy_tx_clk);
		tx_rst2 <= 1'b0;

		err0 = errors;                          // 1, reset values.
		@(negedge phy_tx_clk);
		check_value(32'(mii_tx.tx_en), 32'd0, "tx_en after reset");
		check_value(32'(mii_tx.tx_d), 32'd0, "tx_d after reset");
		check_value(32'(empty), 32'd1, "empty after reset");
		check_value(32'(full), 32'd0, "full after reset");
		finish_test("reset", err0);

		err0       = errors;                    // 2, fill past full with can_tx low.
		start_acc  = accepted_total;
		first_full = -1;
		for (int i = 0; i < 19; i++) begin
			@(posedge phy_tx_clk);
			rng = next_random(rng);
			stb  <= 1'b1;
			data <= rng[7:0];
			@(negedge phy_tx_clk);
			if (i == 1) check_value(32'(empty), 32'd1, "empty before first write settled");
			if (i == 2) check_value(32'(empty), 32'd0, "empty after first write");
			if (full && first_full < 0) first_full = i;
		end
		@(posedge phy_tx_clk);
		stb <= 1'b0;
		@(posedge phy_tx_clk);
		check_value(32'(first_full), 32'(DEPTH), "writes accepted when full rose");
		check_value(32'(accepted_total - start_acc), 32'(DEPTH), "accepted writes");
		check_value(32'(full), 32'd1, "full after overfill");
		finish_test("fill", err0);

		err0         = errors;                  // 3, one frame of 16 bytes.
		start_frames = frames;
		can_tx <= 1'b1;
		wait_drain("single frame");
		check_value(32'(frames - start_frames), 32'd1, "frames for a full FIFO");
		check_value(32'(last_frame_len), 32'(2 * DEPTH), "tx_en cycles in frame");
		@(negedge phy_tx_clk);
		check_value(32'(empty), 32'd1, "empty after frame");
		check_value(32'(full), 32'd0, "full after frame");
		finish_test("drain", err0);

		err0         = errors;                  // 4, random writes and can_tx.
		start_acc    = accepted_total;
		start_frames = frames;
		while (accepted_total - start_acc < RANDOM_BYTES) begin
			@(posedge phy_tx_clk);
			rng = next_random(rng);
			stb  <= rng[1];                     // about half the cycles.
			data <= rng[15:8];
			if (can_tx && rng[24:20] == 5'd0) begin
				can_tx <= 1'b0;                 // rare pause.
			end else if (!can_tx && rng[22:20] == 3'd0) begin
				can_tx <= 1'b1;
			end
		end
		@(posedge phy_tx_clk);
		stb    <= 1'b0;
		can_tx <= 1'b1;
		wait_drain("random traffic");
		check_value(32'(frames > start_frames + 1), 32'd1, "frames under random traffic");
		finish_test("random", err0);

		err0         = errors;                  // 5, pause in the middle of a frame.
		start_frames = frames;
		@(posedge phy_tx_clk);
		can_tx <= 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			rng = next_random(rng);
			stb  <= 1'b1;
			data <= rng[7:0];
			@(posedge phy_tx_clk);
		end
		stb    <= 1'b0;
		can_tx <= 1'b1;
		n = 0;
		while (!(in_frame && frame_len >= 7) && n < DRAIN_LIMIT) begin
			@(posedge phy_tx_clk);
			n++;
		end
		if (!(in_frame && frame_len >= 7)) begin
			errors++;
			$display("long frame did not start after %0d cycles", n);
		end
		can_tx <= 1'b0;
		@(posedge phy_tx_clk);                  // can_tx sampled low here.
		stop_edge = 0;
		for (int k = 1; k <= 8 && stop_edge == 0; k++) begin
			@(posedge phy_tx_clk);
			@(negedge phy_tx_clk);
			if (!mii_tx.tx_en) stop_edge = k;
		end
		check_value(32'(stop_edge >= 1 && stop_edge <= 4), 32'd1, "tx_en fall after can_tx low");
		repeat (20) @(posedge phy_tx_clk);
		check_value(32'(exp_q.size() != 0), 32'd1, "bytes held back during pause");
		check_value(32'(frames - start_frames), 32'd1, "frames during pause");
		can_tx <= 1'b1;
		wait_drain("resume after pause");
		check_value(32'(frames - start_frames), 32'd2, "frames after resume");
		finish_test("pause", err0);

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
